// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := csr_unit_tb
FILELIST := verilog.f
OBJ_DIR  := obj_dir

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard logic/*.svh)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source, a header or the file list changes.
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The run passes only when the pass line shows up in the output.
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q '^STATUS: PASS$$'

clean:
	rm -rf $(OBJ_DIR)

// File: logic/csr_bus_if.sv
`timescale 1ns/1ns
`include "csr_params.svh"

interface csr_bus_if;
    import csr_pkg::*;

    logic [`CSR_ADDR_W-1:0] rd_addr;       // also the write address.
    logic                   wr_strobe;
    logic [`CSR_XLEN-1:0]   wr_data;
    logic                   trap_strobe;
    logic [`CSR_EPC_W-1:0]  trap_epc;
    mcause_t                trap_cause;
    logic [`CSR_XLEN-1:0]   trap_tval;
    logic                   mret_strobe;
    logic [`CSR_XLEN-1:0]   bank_rdata;
    logic                   mstatus_mie;
    logic [2:0]             mie_vec;
    logic [`CSR_EPC_W-1:0]  mepc;
    logic [`CSR_XLEN-1:0]   mtvec;
    logic [`CSR_XLEN-1:0]   cnt_rdata;

    modport ctrl (output rd_addr, wr_strobe, wr_data, trap_strobe, trap_epc, trap_cause,
                  trap_tval, mret_strobe, input bank_rdata, cnt_rdata);
    modport bank (input rd_addr, wr_strobe, wr_data, trap_strobe, trap_epc, trap_cause,
                  trap_tval, mret_strobe, output bank_rdata, mstatus_mie, mie_vec, mepc,
                  mtvec);
    modport counter (input rd_addr, output cnt_rdata);

endinterface

// File: logic/csr_params.svh
`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

// ==========================================================================
// Widths and hart identity.
// ==========================================================================
`define CSR_HARTID          32'h0000_0000
`define CSR_ADDR_W          12
`define CSR_XLEN            32
`define CSR_EPC_W           30
`define CSR_CAUSE_W         4

// ==========================================================================
// Machine CSR addresses.
// ==========================================================================
`define CSR_ADDR_MSTATUS    12'h300
`define CSR_ADDR_MIE        12'h304
`define CSR_ADDR_MTVEC      12'h305
`define CSR_ADDR_MSCRATCH   12'h340
`define CSR_ADDR_MEPC       12'h341
`define CSR_ADDR_MCAUSE     12'h342
`define CSR_ADDR_MTVAL      12'h343
`define CSR_ADDR_MIP        12'h344
`define CSR_ADDR_MCYCLE     12'hB00
`define CSR_ADDR_MCYCLEH    12'hB80
`define CSR_ADDR_MINSTRET   12'hB02
`define CSR_ADDR_MINSTRETH  12'hB82
`define CSR_ADDR_MHARTID    12'hF14

`define CSR_MTVEC_RESET     32'h0000_0100

`endif

// File: logic/csr_pkg.sv
`include "csr_params.svh"

package csr_pkg;

    // ======================================================================
    // Access port encodings.
    // ======================================================================
    typedef enum logic [1:0] {
        CSR_OP_WRITE = 2'b00,
        CSR_OP_SET   = 2'b01,
        CSR_OP_CLEAR = 2'b10,
        CSR_OP_READ  = 2'b11
    } csr_op_e;

    // bit positions of the interrupt lines in ext_int_i, mip and mie.
    typedef enum logic [1:0] {
        IRQ_SOFT  = 2'd0,
        IRQ_TIMER = 2'd1,
        IRQ_EXT   = 2'd2
    } irq_idx_e;

    // ======================================================================
    // Trap cause and address decode.
    // ======================================================================
    typedef struct packed {
        logic                    irq;   // set when the trap came from an interrupt.
        logic [`CSR_CAUSE_W-1:0] code;
    } mcause_t;

    // which block answers a decoded CSR address.
    typedef enum logic [1:0] {
        SEL_BANK    = 2'd0,
        SEL_COUNTER = 2'd1,
        SEL_IRQ     = 2'd2,
        SEL_HARTID  = 2'd3
    } csr_sel_e;

endpackage

// File: logic/csr_register_bank.sv
`timescale 1ns/1ns
`include "csr_params.svh"

module csr_register_bank (
    input   wire logic                      cpu_clock_i,
    input   wire logic                      reset_i,
    csr_bus_if.bank                         bus
);
    import csr_pkg::*;

    logic                   mstatus_mie_q;
    logic                   mstatus_mpie_q;
    logic [2:0]             mie_q;
    logic [`CSR_XLEN-1:0]   mtvec_q;
    logic [`CSR_EPC_W-1:0]  mepc_q;
    mcause_t                mcause_q;
    logic [`CSR_XLEN-1:0]   mtval_q;
    logic [`CSR_XLEN-1:0]   mscratch_q;
    logic [`CSR_XLEN-1:0]   mstatus_word;
    logic [`CSR_XLEN-1:0]   mie_word;
    logic [`CSR_XLEN-1:0]   mcause_word;
    logic [`CSR_XLEN-1:0]   rdata;

    // ======================================================================
    // Register updates.
    // ======================================================================
    always_ff @(posedge cpu_clock_i) begin
        if (reset_i) begin
            mstatus_mie_q <= 1'b0;
            mstatus_mpie_q <= 1'b0;
            mie_q <= '0;
            mtvec_q <= `CSR_MTVEC_RESET;
            mepc_q <= '0;
            mcause_q <= '0;
            mtval_q <= '0;
            mscratch_q <= '0;
        end else begin
            if (bus.wr_strobe) begin
                case (bus.rd_addr)
                    `CSR_ADDR_MSTATUS: begin
                        mstatus_mie_q <= bus.wr_data[3];
                        mstatus_mpie_q <= bus.wr_data[7];
                    end
                    `CSR_ADDR_MIE: mie_q <= {bus.wr_data[11], bus.wr_data[7], bus.wr_data[3]};
                    `CSR_ADDR_MTVEC: mtvec_q <= {bus.wr_data[`CSR_XLEN-1:2], 2'b00};  // direct mode only.
                    `CSR_ADDR_MSCRATCH: mscratch_q <= bus.wr_data;
                    `CSR_ADDR_MEPC: mepc_q <= bus.wr_data[`CSR_XLEN-1:2];
                    `CSR_ADDR_MCAUSE: begin
                        mcause_q.irq <= bus.wr_data[`CSR_XLEN-1];
                        mcause_q.code <= bus.wr_data[`CSR_CAUSE_W-1:0];
                    end
                    `CSR_ADDR_MTVAL: mtval_q <= bus.wr_data;
                    default: ;
                endcase
            end
            // these come later so that they override a write on the same edge.
            if (bus.trap_strobe) begin
                mepc_q <= bus.trap_epc;
                mcause_q <= bus.trap_cause;
                mtval_q <= bus.trap_tval;
                mstatus_mpie_q <= mstatus_mie_q;
                mstatus_mie_q <= 1'b0;
            end else if (bus.mret_strobe) begin
                mstatus_mie_q <= mstatus_mpie_q;
                mstatus_mpie_q <= 1'b1;
            end
        end
    end

    // ======================================================================
    // Read side.
    // ======================================================================
    assign mstatus_word = {19'd0, 2'b11, 3'd0, mstatus_mpie_q, 3'd0, mstatus_mie_q, 3'd0};  // mpp is fixed at machine.
    assign mie_word = {20'd0, mie_q[IRQ_EXT], 3'd0, mie_q[IRQ_TIMER], 3'd0, mie_q[IRQ_SOFT], 3'd0};
    assign mcause_word = {mcause_q.irq, {(`CSR_XLEN-1-`CSR_CAUSE_W){1'b0}}, mcause_q.code};

    always_comb begin
        case (bus.rd_addr)
            `CSR_ADDR_MSTATUS:  rdata = mstatus_word;
            `CSR_ADDR_MIE:      rdata = mie_word;
            `CSR_ADDR_MTVEC:    rdata = mtvec_q;
            `CSR_ADDR_MSCRATCH: rdata = mscratch_q;
            `CSR_ADDR_MEPC:     rdata = {mepc_q, 2'b00};
            `CSR_ADDR_MCAUSE:   rdata = mcause_word;
            `CSR_ADDR_MTVAL:    rdata = mtval_q;
            default:            rdata = '0;
        endcase
    end

    assign bus.bank_rdata = rdata;
    assign bus.mstatus_mie = mstatus_mie_q;
    assign bus.mie_vec = mie_q;
    assign bus.mepc = mepc_q;
    assign bus.mtvec = mtvec_q;

    a_trap_mret_exclusive: assert property (@(posedge cpu_clock_i) disable iff (reset_i)
        !(bus.trap_strobe && bus.mret_strobe));

endmodule

// File: logic/csr_trap_control.sv
`timescale 1ns/1ns
`include "csr_params.svh"

module csr_trap_control #(
    parameter logic [`CSR_XLEN-1:0] HARTID = `CSR_HARTID
) (
    input   wire logic                      cpu_clock_i,
    input   wire logic                      reset_i,
    input   wire logic                      csr_valid_i,
    input   wire logic                      csr_wr_en_i,
    input        csr_pkg::csr_op_e          csr_opcode_i,
    input   wire logic [`CSR_ADDR_W-1:0]    csr_address_i,
    input   wire logic [`CSR_XLEN-1:0]      csr_data_i,
    input   wire logic                      take_exception_i,
    input   wire logic [`CSR_EPC_W-1:0]     epc_i,
    input   wire logic [`CSR_XLEN-1:0]      mtval_i,
    input   wire logic [`CSR_CAUSE_W-1:0]   mcause_i,
    input   wire logic                      mret_i,
    input   wire logic                      irq_req_i,
    input        csr_pkg::mcause_t          irq_cause_i,
    input   wire logic [2:0]                mip_i,
    csr_bus_if.ctrl                         bus,
    output       logic                      csr_done_o,
    output       logic                      csr_excp_o,
    output       logic [`CSR_XLEN-1:0]      csr_data_o,
    output       logic                      take_interrupt_o
);
    import csr_pkg::*;

    csr_sel_e               sel;
    logic                   known;
    logic                   read_only;
    logic                   illegal;
    logic [`CSR_XLEN-1:0]   mip_word;
    logic [`CSR_XLEN-1:0]   old_data;
    logic [`CSR_XLEN-1:0]   new_data;
    mcause_t                exc_cause;

    // ======================================================================
    // Address decode and legality.
    // ======================================================================
    always_comb begin
        known = 1'b1;
        read_only = 1'b0;
        sel = SEL_BANK;
        case (csr_address_i)
            `CSR_ADDR_MSTATUS, `CSR_ADDR_MIE, `CSR_ADDR_MTVEC, `CSR_ADDR_MSCRATCH,
            `CSR_ADDR_MEPC, `CSR_ADDR_MCAUSE, `CSR_ADDR_MTVAL: sel = SEL_BANK;
            `CSR_ADDR_MCYCLE, `CSR_ADDR_MCYCLEH, `CSR_ADDR_MINSTRET,
            `CSR_ADDR_MINSTRETH: begin
                sel = SEL_COUNTER;
                read_only = 1'b1;  // the counters are read only in this core.
            end
            `CSR_ADDR_MIP: begin
                sel = SEL_IRQ;
                read_only = 1'b1;
            end
            `CSR_ADDR_MHARTID: begin
                sel = SEL_HARTID;
                read_only = 1'b1;
            end
            default: known = 1'b0;
        endcase
    end

    assign illegal = !known || (csr_wr_en_i && read_only);
    assign mip_word = {20'd0, mip_i[IRQ_EXT], 3'd0, mip_i[IRQ_TIMER], 3'd0, mip_i[IRQ_SOFT], 3'd0};

    always_comb begin
        case (sel)
            SEL_BANK:    old_data = bus.bank_rdata;
            SEL_COUNTER: old_data = bus.cnt_rdata;
            SEL_IRQ:     old_data = mip_word;
            default:     old_data = HARTID;
        endcase
        case (csr_opcode_i)
            CSR_OP_WRITE: new_data = csr_data_i;
            CSR_OP_SET:   new_data = old_data | csr_data_i;
            CSR_OP_CLEAR: new_data = old_data & ~csr_data_i;
            default:      new_data = old_data;  // a read rewrites the old value.
        endcase
    end

    assign bus.rd_addr = csr_address_i;
    assign bus.wr_data = new_data;
    assign bus.wr_strobe = csr_valid_i && csr_wr_en_i && !illegal;

    always_ff @(posedge cpu_clock_i) begin
        if (reset_i) begin
            csr_done_o <= 1'b0;
            csr_excp_o <= 1'b0;
            csr_data_o <= '0;
        end else begin
            csr_done_o <= csr_valid_i;
            csr_excp_o <= csr_valid_i && illegal;
            csr_data_o <= (csr_valid_i && !illegal) ? old_data : '0;
        end
    end

    // ======================================================================
    // Trap arbitration.
    // ======================================================================
    assign exc_cause = '{irq: 1'b0, code: mcause_i};
    assign take_interrupt_o = irq_req_i && !take_exception_i;  // exceptions win.
    assign bus.trap_strobe = take_exception_i || take_interrupt_o;
    assign bus.trap_epc = epc_i;
    assign bus.trap_cause = take_exception_i ? exc_cause : irq_cause_i;
    assign bus.trap_tval = take_exception_i ? mtval_i : '0;
    assign bus.mret_strobe = mret_i && !bus.trap_strobe;

    // the bank clears MIE on the trap edge, which ends the request.
    a_interrupt_single_pulse: assert property (@(posedge cpu_clock_i) disable iff (reset_i)
        take_interrupt_o |=> !take_interrupt_o);

endmodule

// File: logic/interrupt_arbiter.sv
`timescale 1ns/1ns
`include "csr_params.svh"

module interrupt_arbiter (
    input   wire logic                      cpu_clock_i,
    input   wire logic                      reset_i,
    input   wire logic [2:0]                ext_int_i,
    input   wire logic [2:0]                mie_vec_i,
    input   wire logic                      mstatus_mie_i,
    output       logic [2:0]                mip_o,
    output       logic                      irq_req_o,
    output       csr_pkg::mcause_t          irq_cause_o
);
    import csr_pkg::*;

    logic [2:0]     pending;
    irq_idx_e       src;

    // the lines are sampled once so that mip follows them one cycle late.
    always_ff @(posedge cpu_clock_i) begin
        if (reset_i) begin
            mip_o <= '0;
        end else begin
            mip_o <= ext_int_i;
        end
    end

    assign pending = mip_o & mie_vec_i;
    assign irq_req_o = mstatus_mie_i && (pending != '0);

    // Fixed priority. External first, then software, then timer.
    always_comb begin
        if (pending[IRQ_EXT]) begin
            src = IRQ_EXT;
        end else if (pending[IRQ_SOFT]) begin
            src = IRQ_SOFT;
        end else begin
            src = IRQ_TIMER;
        end
    end

    // cause codes 3, 7 and 11 are the bit position with 2'b11 appended.
    assign irq_cause_o.irq = 1'b1;
    assign irq_cause_o.code = {src, 2'b11};

endmodule

// File: logic/machine_csr_unit.sv
`timescale 1ns/1ns
`include "csr_params.svh"

module machine_csr_unit #(
    parameter logic [`CSR_XLEN-1:0] HARTID = `CSR_HARTID
) (
    input   wire logic                      cpu_clock_i,
    input   wire logic                      reset_i,
    input   wire logic                      csr_valid_i,
    input   wire logic                      csr_wr_en_i,
    input        csr_pkg::csr_op_e          csr_opcode_i,
    input   wire logic [`CSR_ADDR_W-1:0]    csr_address_i,
    input   wire logic [`CSR_XLEN-1:0]      csr_data_i,
    input   wire logic                      take_exception_i,
    input   wire logic [`CSR_EPC_W-1:0]     epc_i,
    input   wire logic [`CSR_XLEN-1:0]      mtval_i,
    input   wire logic [`CSR_CAUSE_W-1:0]   mcause_i,
    input   wire logic                      mret_i,
    input   wire logic                      commit0_i,
    input   wire logic                      commit1_i,
    input   wire logic [2:0]                ext_int_i,
    output       logic                      csr_done_o,
    output       logic                      csr_excp_o,
    output       logic [`CSR_XLEN-1:0]      csr_data_o,
    output       logic                      take_interrupt_o,
    output       logic [2:0]                mip_o,
    output       logic                      mie_o,
    output       logic [`CSR_EPC_W-1:0]     mepc_o,
    output       logic [`CSR_XLEN-1:0]      mtvec_o
);
    import csr_pkg::*;

    logic       irq_req;
    mcause_t    irq_cause;

    csr_bus_if bus ();

    csr_trap_control #(.HARTID(HARTID)) ctrl (
        .cpu_clock_i, .reset_i,
        .csr_valid_i, .csr_wr_en_i, .csr_opcode_i, .csr_address_i, .csr_data_i,
        .take_exception_i, .epc_i, .mtval_i, .mcause_i, .mret_i,
        .irq_req_i(irq_req), .irq_cause_i(irq_cause), .mip_i(mip_o),
        .bus(bus.ctrl),
        .csr_done_o, .csr_excp_o, .csr_data_o, .take_interrupt_o
    );

    csr_register_bank bank (.cpu_clock_i, .reset_i, .bus(bus.bank));

    interrupt_arbiter arbiter (
        .cpu_clock_i, .reset_i, .ext_int_i,
        .mie_vec_i(bus.mie_vec), .mstatus_mie_i(bus.mstatus_mie),
        .mip_o, .irq_req_o(irq_req), .irq_cause_o(irq_cause)
    );

    retire_counter counters (.cpu_clock_i, .reset_i, .commit0_i, .commit1_i, .bus(bus.counter));

    assign mie_o = bus.mstatus_mie;  // global machine interrupt enable.
    assign mepc_o = bus.mepc;
    assign mtvec_o = bus.mtvec;

endmodule

// File: logic/retire_counter.sv
`timescale 1ns/1ns
`include "csr_params.svh"

module retire_counter (
    input   wire logic                      cpu_clock_i,
    input   wire logic                      reset_i,
    input   wire logic                      commit0_i,
    input   wire logic                      commit1_i,
    csr_bus_if.counter                      bus
);

    logic [63:0]            mcycle_q;
    logic [63:0]            minstret_q;
    logic [1:0]             commit_sum;
    logic [`CSR_XLEN-1:0]   rdata;

    assign commit_sum = {1'b0, commit0_i} + {1'b0, commit1_i};  // both slots may retire together.

    always_ff @(posedge cpu_clock_i) begin
        if (reset_i) begin
            mcycle_q <= '0;
            minstret_q <= '0;
        end else begin
            mcycle_q <= mcycle_q + 64'd1;
            minstret_q <= minstret_q + {62'd0, commit_sum};
        end
    end

    // ======================================================================
    // Read side.
    // ======================================================================
    always_comb begin
        case (bus.rd_addr)
            `CSR_ADDR_MCYCLE:    rdata = mcycle_q[31:0];
            `CSR_ADDR_MCYCLEH:   rdata = mcycle_q[63:32];
            `CSR_ADDR_MINSTRET:  rdata = minstret_q[31:0];
            `CSR_ADDR_MINSTRETH: rdata = minstret_q[63:32];
            default:             rdata = '0;
        endcase
    end

    assign bus.cnt_rdata = rdata;

endmodule

// File: test/csr_stimulus.txt
# in:  valid wr_en op addr wdata exc epc mtval cause mret commit0 commit1 ext_int
# out: done excp rdata take_int mip mie_o mepc_o mtvec_o (seen after the edge)
# reads after reset
1 0 3 300 00000000 0 00000000 00000000 0 0 0 0 0  1 0 00001800 0 0 0 00000000 00000100
1 0 3 304 00000000 0 00000000 00000000 0 0 0 0 0  1 0 00000000 0 0 0 00000000 00000100
1 0 3 305 00000000 0 00000000 00000000 0 0 0 0 0  1 0 00000100 0 0 0 00000000 00000100
1 0 3 341 00000000 0 00000000 00000000 0 0 0 0 0  1 0 00000000 0 0 0 00000000 00000100
1 0 3 342 00000000 0 00000000 00000000 0 0 0 0 0  1 0 00000000 0 0 0 00000000 00000100
1 0 3 343 00000000 0 00000000 00000000 0 0 0 0 0  1 0 00000000 0 0 0 00000000 00000100
1 0 3 340 00000000 0 00000000 00000000 0 0 0 0 0  1 0 00000000 0 0 0 00000000 00000100
1 0 3 F14 00000000 0 00000000 00000000 0 0 0 0 0  1 0 00000000 0 0 0 00000000 00000100
1 0 3 344 00000000 0 00000000 00000000 0 0 0 0 0  1 0 00000000 0 0 0 00000000 00000100
0 0 3 000 00000000 0 00000000 00000000 0 0 0 0 0  0 0 00000000 0 0 0 00000000 00000100
# write, set and clear on mscratch and mie
1 1 0 340 12345678 0 00000000 00000000 0 0 0 0 0  1 0 00000000 0 0 0 00000000 00000100
1 1 1 340 000000F0 0 00000000 00000000 0 0 0 0 0  1 0 12345678 0 0 0 00000000 00000100
1 1 2 340 00000008 0 00000000 00000000 0 0 0 0 0  1 0 123456F8 0 0 0 00000000 00000100
1 0 3 340 00000000 0 00000000 00000000 0 0 0 0 0  1 0 123456F0 0 0 0 00000000 00000100
1 1 0 304 00000888 0 00000000 00000000 0 0 0 0 0  1 0 00000000 0 0 0 00000000 00000100
1 1 2 304 00000808 0 00000000 00000000 0 0 0 0 0  1 0 00000888 0 0 0 00000000 00000100
1 0 3 304 00000000 0 00000000 00000000 0 0 0 0 0  1 0 00000080 0 0 0 00000000 00000100
# illegal accesses
1 0 3 7C0 00000000 0 00000000 00000000 0 0 0 0 0  1 1 00000000 0 0 0 00000000 00000100
1 1 0 F14 FFFFFFFF 0 00000000 00000000 0 0 0 0 0  1 1 00000000 0 0 0 00000000 00000100
1 1 0 B02 00001000 0 00000000 00000000 0 0 0 0 0  1 1 00000000 0 0 0 00000000 00000100
1 0 3 B02 00000000 0 00000000 00000000 0 0 0 0 0  1 0 00000000 0 0 0 00000000 00000100
# exception entry and mret
1 1 1 300 00000008 0 00000000 00000000 0 0 0 0 0  1 0 00001800 0 0 1 00000000 00000100
0 0 3 000 00000000 1 00000040 DEADBEEF 2 0 0 0 0  0 0 00000000 0 0 0 00000040 00000100
1 0 3 342 00000000 0 00000000 00000000 0 0 0 0 0  1 0 00000002 0 0 0 00000040 00000100
1 0 3 343 00000000 0 00000000 00000000 0 0 0 0 0  1 0 DEADBEEF 0 0 0 00000040 00000100
1 0 3 341 00000000 0 00000000 00000000 0 0 0 0 0  1 0 00000100 0 0 0 00000040 00000100
1 0 3 300 00000000 0 00000000 00000000 0 0 0 0 0  1 0 00001880 0 0 0 00000040 00000100
0 0 3 000 00000000 0 00000000 00000000 0 1 0 0 0  0 0 00000000 0 0 1 00000040 00000100
1 0 3 300 00000000 0 00000000 00000000 0 0 0 0 0  1 0 00001888 0 0 1 00000040 00000100
# timer interrupt, then external over software
0 0 3 000 00000000 0 00000000 00000000 0 0 0 0 2  0 0 00000000 1 2 1 00000040 00000100
0 0 3 000 00000000 0 00000123 00000000 0 0 0 0 2  0 0 00000000 0 2 0 00000123 00000100
1 0 3 342 00000000 0 00000000 00000000 0 0 0 0 0  1 0 80000007 0 0 0 00000123 00000100
1 1 0 304 00000888 0 00000000 00000000 0 0 0 0 0  1 0 00000080 0 0 0 00000123 00000100
0 0 3 000 00000000 0 00000000 00000000 0 1 0 0 0  0 0 00000000 0 0 1 00000123 00000100
0 0 3 000 00000000 0 00000000 00000000 0 0 0 0 5  0 0 00000000 1 5 1 00000123 00000100
0 0 3 000 00000000 0 00000200 00000000 0 0 0 0 5  0 0 00000000 0 5 0 00000200 00000100
1 0 3 342 00000000 0 00000000 00000000 0 0 0 0 0  1 0 8000000B 0 0 0 00000200 00000100
1 0 3 343 00000000 0 00000000 00000000 0 0 0 0 0  1 0 00000000 0 0 0 00000200 00000100
# commits of 1, 2 and 1, then minstret and mcycle (42 cycles since reset fell)
0 0 3 000 00000000 0 00000000 00000000 0 0 1 0 0  0 0 00000000 0 0 0 00000200 00000100
0 0 3 000 00000000 0 00000000 00000000 0 0 1 1 0  0 0 00000000 0 0 0 00000200 00000100
0 0 3 000 00000000 0 00000000 00000000 0 0 0 1 0  0 0 00000000 0 0 0 00000200 00000100
1 0 3 B02 00000000 0 00000000 00000000 0 0 0 0 0  1 0 00000004 0 0 0 00000200 00000100
1 0 3 B00 00000000 0 00000000 00000000 0 0 0 0 0  1 0 0000002A 0 0 0 00000200 00000100
1 0 3 B80 00000000 0 00000000 00000000 0 0 0 0 0  1 0 00000000 0 0 0 00000200 00000100
0 0 3 000 00000000 0 00000000 00000000 0 0 0 0 0  0 0 00000000 0 0 0 00000200 00000100

// File: test/csr_unit_tb.sv
`timescale 1ns/1ns

module csr_unit_tb;
    import csr_pkg::*;

    localparam int    MAX_LINES = 200;
    localparam int    MAX_VECS  = 100;
    localparam int    IN_COLS   = 13;
    localparam int    EXP_COLS  = 8;
    localparam string STIM_FILE = "test/csr_stimulus.txt";

    logic           cpu_clock = 1'b0;
    logic           reset;
    logic           csr_valid;
    logic           csr_wr_en;
    csr_op_e        csr_opcode;
    logic [11:0]    csr_address;
    logic [31:0]    csr_data;
    logic           take_exception;
    logic [29:0]    epc;
    logic [31:0]    mtval;
    logic [3:0]     mcause;
    logic           mret;
    logic           commit0;
    logic           commit1;
    logic [2:0]     ext_int;
    logic           csr_done;
    logic           csr_excp;
    logic [31:0]    csr_rdata;
    logic           take_interrupt;
    logic [2:0]     mip;
    logic           mie;
    logic [29:0]    mepc;
    logic [31:0]    mtvec;

    logic [31:0]    in_vec [0:MAX_VECS-1][0:IN_COLS-1];
    logic [31:0]    exp_vec [0:MAX_VECS-1][0:EXP_COLS-1];
    int             line_of [0:MAX_VECS-1];  // file line of each vector, for error lines.
    int             num_vecs = 0;
    int             cur_vec = 0;
    int             check_count = 0;
    int             error_count = 0;

    always #2 cpu_clock = ~cpu_clock;

    machine_csr_unit dut_i (
        .cpu_clock_i(cpu_clock), .reset_i(reset),
        .csr_valid_i(csr_valid), .csr_wr_en_i(csr_wr_en), .csr_opcode_i(csr_opcode),
        .csr_address_i(csr_address), .csr_data_i(csr_data),
        .take_exception_i(take_exception), .epc_i(epc), .mtval_i(mtval), .mcause_i(mcause),
        .mret_i(mret), .commit0_i(commit0), .commit1_i(commit1), .ext_int_i(ext_int),
        .csr_done_o(csr_done), .csr_excp_o(csr_excp), .csr_data_o(csr_rdata),
        .take_interrupt_o(take_interrupt), .mip_o(mip), .mie_o(mie), .mepc_o(mepc),
        .mtvec_o(mtvec)
    );

    // ==========================================================================
    // Stimulus file.
    // ==========================================================================
    task automatic load_stimulus();
        int          fd;
        int          lines_read;
        int          fields;
        int          i;
        string       text;
        logic [31:0] f [0:IN_COLS+EXP_COLS-1];
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("could not open the stimulus file %s", STIM_FILE);
            error_count++;
            return;
        end
        lines_read = 0;
        while (!$feof(fd) && lines_read < MAX_LINES) begin
            text = "";
            if ($fgets(text, fd) == 0) begin
                break;
            end
            lines_read++;
            if (text.len() < 2 || text.getc(0) == "#") begin
                continue;  // blank or comment line.
            end
            fields = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20]);
            if (fields != IN_COLS + EXP_COLS) begin
                $display("line %0d of the stimulus file is malformed: %0d of %0d fields read",
                    lines_read, fields, IN_COLS + EXP_COLS);
                error_count++;
            end else if (num_vecs == MAX_VECS) begin
                $display("the stimulus file holds more than %0d vectors", MAX_VECS);
                error_count++;
            end else begin
                for (i = 0; i < IN_COLS; i++) begin
                    in_vec[num_vecs][i] = f[i];
                end
                for (i = 0; i < EXP_COLS; i++) begin
                    exp_vec[num_vecs][i] = f[IN_COLS + i];
                end
                line_of[num_vecs] = lines_read;
                num_vecs++;
            end
        end
        if (lines_read == MAX_LINES && !$feof(fd)) begin
            $display("stopped reading the stimulus file after %0d lines", MAX_LINES);
            error_count++;
        end
        if (num_vecs == 0) begin
            $display("no vectors were loaded from the stimulus file");
            error_count++;
        end
        $fclose(fd);
    endtask

    // ==========================================================================
    // Drive and check.
    // ==========================================================================
    task automatic idle_inputs();
        csr_valid = 1'b0;
        csr_wr_en = 1'b0;
        csr_opcode = CSR_OP_READ;
        csr_address = '0;
        csr_data = '0;
        take_exception = 1'b0;
        epc = '0;
        mtval = '0;
        mcause = '0;
        mret = 1'b0;
        commit0 = 1'b0;
        commit1 = 1'b0;
        ext_int = '0;
    endtask

    task automatic apply_inputs(input int v);
        csr_valid = in_vec[v][0][0];
        csr_wr_en = in_vec[v][1][0];
        csr_opcode = csr_op_e'(in_vec[v][2][1:0]);
        csr_address = in_vec[v][3][11:0];
        csr_data = in_vec[v][4];
        take_exception = in_vec[v][5][0];
        epc = in_vec[v][6][29:0];
        mtval = in_vec[v][7];
        mcause = in_vec[v][8][3:0];
        mret = in_vec[v][9][0];
        commit0 = in_vec[v][10][0];
        commit1 = in_vec[v][11][0];
        ext_int = in_vec[v][12][2:0];
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("error at %0t ns: stimulus line %0d, %s is %h, expected %h",
                $time, line_of[cur_vec], what, got, expected);
        end
    endtask

    task automatic check_outputs(input int v);
        check_value("csr_done_o", {31'd0, csr_done}, exp_vec[v][0]);
        check_value("csr_excp_o", {31'd0, csr_excp}, exp_vec[v][1]);
        check_value("csr_data_o", csr_rdata, exp_vec[v][2]);
        check_value("take_interrupt_o", {31'd0, take_interrupt}, exp_vec[v][3]);
        check_value("mip_o", {29'd0, mip}, exp_vec[v][4]);
        check_value("mie_o", {31'd0, mie}, exp_vec[v][5]);
        check_value("mepc_o", {2'd0, mepc}, exp_vec[v][6]);
        check_value("mtvec_o", mtvec, exp_vec[v][7]);
    endtask

    initial begin
        int v;
        reset = 1'b1;
        idle_inputs();
        load_stimulus();
        repeat (10) @(posedge cpu_clock);
        #1;
        reset = 1'b0;
        for (v = 0; v < num_vecs; v++) begin
            apply_inputs(v);
            @(posedge cpu_clock);
            #1;  // registered outputs have settled, next inputs not yet applied.
            cur_vec = v;
            check_outputs(v);
        end
        idle_inputs();
        $display("%0d vectors, %0d checks, %0d errors", num_vecs, check_count, error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+logic
logic/csr_pkg.sv
logic/csr_bus_if.sv
logic/interrupt_arbiter.sv
logic/retire_counter.sv
logic/csr_register_bank.sv
logic/csr_trap_control.sv
logic/machine_csr_unit.sv
test/csr_unit_tb.sv
